/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mpu
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/mpu_ctrl.sv */
// MPU control block that pops the queue, issues legal requests to the bus and holds faults
// until all outstanding bus responses are back, then requests the fault response
`timescale 1ns/100ps

`include "mpu_settings.svh"

module mpu_ctrl import mpu_pkg::*, pma_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        head_valid_i,
  input  core_req_t   head_i,
  input  logic        fault_i,
  input  memtype_t    memtype_i,
  output logic        pop_o,
  output logic        bus_req_valid_o,
  output bus_req_t    bus_req_o,
  input  logic        bus_credit_i,
  input  logic        bus_resp_valid_i,
  output logic        err_resp_valid_o,
  output mpu_status_e err_status_o
);

  mpu_state_e  state_q;
  mpu_state_e  state_d;
  credit_cnt_t credit_q;
  credit_cnt_t credit_d;
  credit_cnt_t outst_q;
  credit_cnt_t outst_d;
  mpu_status_e err_status_q;
  logic        issue;
  logic        take_fault;
  logic        bus_req_valid_q;
  bus_req_t    bus_req_q;

  // Only an idle FSM looks at the head
  assign issue      = (state_q == MPU_IDLE) && head_valid_i && !fault_i && (credit_q != '0);
  assign take_fault = (state_q == MPU_IDLE) && head_valid_i && fault_i;
  assign pop_o      = issue || take_fault;

  // Spend a credit per issued request and regain one per bus pulse
  assign credit_d = credit_q - credit_cnt_t'(issue) + credit_cnt_t'(bus_credit_i);
  // One more per issued request and one less per returned response
  assign outst_d  = outst_q + credit_cnt_t'(issue) - credit_cnt_t'(bus_resp_valid_i);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d          = state_q;
    err_resp_valid_o = 1'b0;
    case (state_q)
      MPU_IDLE: begin
        if (take_fault) begin
          state_d = head_i.we ? MPU_WR_ERR_WAIT : MPU_RE_ERR_WAIT;
        end
      end
      MPU_RE_ERR_WAIT,
      MPU_WR_ERR_WAIT: begin
        // Leaving as the last response drains keeps responses in order
        if (outst_d == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: begin
        err_resp_valid_o = 1'b1;
        state_d          = MPU_IDLE;
      end
      default: state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= MPU_IDLE;
      credit_q        <= credit_cnt_t'(`MPU_BUS_CREDITS);
      outst_q         <= '0;
      err_status_q    <= MPU_OK;
      bus_req_valid_q <= 1'b0;
    end else begin
      state_q         <= state_d;
      credit_q        <= credit_d;
      outst_q         <= outst_d;
      bus_req_valid_q <= issue;
      // Direction of the blocked access follows the wait state
      if (state_d == MPU_ERR_RESP) begin
        err_status_q <= (state_q == MPU_WR_ERR_WAIT) ? MPU_WR_FAULT : MPU_RE_FAULT;
      end
    end
  end

  // Bus request payload
  always_ff @(posedge clk) begin
    if (issue) begin
      bus_req_q.addr    <= head_i.addr;
      bus_req_q.we      <= head_i.we;
      bus_req_q.wdata   <= head_i.wdata;
      bus_req_q.size    <= head_i.size;
      bus_req_q.memtype <= memtype_i;
    end
  end

  assign bus_req_valid_o = bus_req_valid_q;
  assign bus_req_o       = bus_req_q;
  assign err_status_o    = err_status_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_bus_req_only_idle : assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (state_q == MPU_IDLE))
    else $error("bus request while the FSM handles a fault");

  a_err_resp_drained : assert property (@(posedge clk) disable iff (!rst_n)
    err_resp_valid_o |-> (outst_q == '0))
    else $error("fault response with bus responses outstanding");

  a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= credit_cnt_t'(`MPU_BUS_CREDITS))
    else $error("bus returned more credits than it was given");

  a_resp_expected : assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> (outst_q != '0))
    else $error("bus response without an outstanding request");

endmodule

/* hw/mpu_pkg.sv */
// Types for core and bus transactions, responses and the MPU control FSM
// Imported by the queue, the control block, the response merge and the top level
package mpu_pkg;

  import pma_pkg::*;

  //////////////////////////////
  // Transactions
  //////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_e;

  // Request as issued by the load/store unit
  typedef struct packed {
    addr_t        addr;
    logic         we;
    data_t        wdata;
    access_size_e size;
    logic         instr;
    logic         atomic;
  } core_req_t;

  // Request as forwarded to the bus, attributes folded into memtype
  typedef struct packed {
    addr_t        addr;
    logic         we;
    data_t        wdata;
    access_size_e size;
    memtype_t     memtype;
  } bus_req_t;

  //////////////////////////////
  // Responses and control
  //////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef struct packed {
    data_t       rdata;
    mpu_status_e status;
  } core_resp_t;

  typedef enum logic [1:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_ERR_RESP
  } mpu_state_e;

  // Credit and outstanding response counters
  typedef logic [2:0] credit_cnt_t;

endpackage

/* hw/mpu_req_fifo.sv */
// Request queue between the core and the MPU control block
// Every popped entry hands one credit back to the core on the next cycle
`timescale 1ns/100ps

`include "mpu_settings.svh"

module mpu_req_fifo import mpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push_i,
  input  core_req_t push_data_i,
  input  logic      pop_i,
  output logic      head_valid_o,
  output core_req_t head_o,
  output logic      core_credit_o
);

  localparam int DEPTH = `MPU_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  core_req_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // One extra bit so that a full queue is distinct from an empty one
  logic [PTR_W:0]   count_q;
  logic             pop_en;
  logic             core_credit_q;

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem[rd_ptr_q];
  // Popping an empty queue is ignored
  assign pop_en       = pop_i && head_valid_o;

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  //////////////////////////////
  // Pointers and fill level
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      core_credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        // Wrap at the last entry, depth need not be a power of two
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop_en) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      case ({push_i, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Credit goes back one cycle after the entry leaves
      core_credit_q <= pop_en;
    end
  end

  assign core_credit_o = core_credit_q;

  // Core may only push while it holds a credit, so a full queue means overspending
  a_no_push_when_full : assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (count_q < (PTR_W + 1)'(DEPTH)))
    else $error("core pushed into a full request queue");

endmodule

/* hw/mpu_resp_mux.sv */
// Response merge toward the core
// Registers either a bus response with OK status or a fault response from the FSM
`timescale 1ns/100ps

module mpu_resp_mux import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        bus_resp_valid_i,
  input  data_t       bus_rdata_i,
  input  logic        err_resp_valid_i,
  input  mpu_status_e err_status_i,
  output logic        core_resp_valid_o,
  output core_resp_t  core_resp_o
);

  core_resp_t resp_d;
  logic       resp_valid_q;
  core_resp_t resp_q;

  // Select the source, faults carry no read data
  always_comb begin
    if (err_resp_valid_i) begin
      resp_d.rdata  = '0;
      resp_d.status = err_status_i;
    end else begin
      resp_d.rdata  = bus_rdata_i;
      resp_d.status = MPU_OK;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= bus_resp_valid_i || err_resp_valid_i;
    end
  end

  // Payload only moves with a valid response
  always_ff @(posedge clk) begin
    if (bus_resp_valid_i || err_resp_valid_i) begin
      resp_q <= resp_d;
    end
  end

  assign core_resp_valid_o = resp_valid_q;
  assign core_resp_o       = resp_q;

  // FSM waits for the bus to drain before it answers, so both never meet here
  a_no_resp_collision : assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_resp_valid_i && err_resp_valid_i))
    else $error("bus and fault response collide");

endmodule

/* hw/mpu_settings.svh */
// Build-time settings of the MPU: queue depth, bus credits and the fixed PMA region table
// Included by every module that sizes itself from these values
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// Request queue entries, also the core's initial credit count
`define MPU_REQ_DEPTH   2
// Bus credits the MPU holds after reset
`define MPU_BUS_CREDITS 2

// Region table, word addresses, low inclusive and high exclusive
// Attribute mask order is {main, atomic, bufferable, cacheable}
`define PMA_NUM_REGIONS 3

// Main memory, full attributes
`define PMA_R0_LOW  30'h0000_0000
`define PMA_R0_HIGH 30'h0400_0000
`define PMA_R0_ATTR 4'b1111
// I/O space, bufferable only
`define PMA_R1_LOW  30'h0400_0000
`define PMA_R1_HIGH 30'h0800_0000
`define PMA_R1_ATTR 4'b0010
// Main without atomics, overlaps regions 0 and 1
`define PMA_R2_LOW  30'h0200_0000
`define PMA_R2_HIGH 30'h0600_0000
`define PMA_R2_ATTR 4'b1000

`endif

/* hw/mpu_top.sv */
// Top level of the MPU on one load/store port
// Queue, PMA lookup, control FSM and response merge wired together
`timescale 1ns/100ps

module mpu_top import mpu_pkg::*, pma_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Core request and response
  input  logic       core_req_valid_i,
  input  core_req_t  core_req_i,
  output logic       core_credit_o,
  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o,
  // Bus request and response
  output logic       bus_req_valid_o,
  output bus_req_t   bus_req_o,
  input  logic       bus_credit_i,
  input  logic       bus_resp_valid_i,
  input  data_t      bus_rdata_i
);

  logic        head_valid;
  core_req_t   head;
  logic        pop;
  logic        fault;
  memtype_t    memtype;
  logic        err_resp_valid;
  mpu_status_e err_status;

  //////////////////////////////
  // Request side
  //////////////////////////////

  mpu_req_fifo u_req_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (core_req_valid_i),
    .push_data_i   (core_req_i),
    .pop_i         (pop),
    .head_valid_o  (head_valid),
    .head_o        (head),
    .core_credit_o (core_credit_o)
  );

  // Raw attributes stay inside the lookup, only memtype and fault leave it
  pma_lookup u_pma_lookup (
    .head_i    (head),
    .attr_o    (),
    .memtype_o (memtype),
    .fault_o   (fault)
  );

  mpu_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .head_valid_i     (head_valid),
    .head_i           (head),
    .fault_i          (fault),
    .memtype_i        (memtype),
    .pop_o            (pop),
    .bus_req_valid_o  (bus_req_valid_o),
    .bus_req_o        (bus_req_o),
    .bus_credit_i     (bus_credit_i),
    .bus_resp_valid_i (bus_resp_valid_i),
    .err_resp_valid_o (err_resp_valid),
    .err_status_o     (err_status)
  );

  // Response side
  mpu_resp_mux u_resp_mux (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_rdata_i       (bus_rdata_i),
    .err_resp_valid_i  (err_resp_valid),
    .err_status_i      (err_status),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

endmodule

/* hw/pma_lookup.sv */
// PMA check of the request at the queue head against the fixed region table
// Purely combinational, the control block uses the fault flag and the memory type
`timescale 1ns/100ps

`include "mpu_settings.svh"

module pma_lookup import mpu_pkg::*, pma_pkg::*; (
  input  core_req_t head_i,
  output pma_attr_t attr_o,
  output memtype_t  memtype_o,
  output logic      fault_o
);

  // Region table built from the settings header
  localparam pma_region_t REGION_TAB [`PMA_NUM_REGIONS] = '{
    '{low: `PMA_R0_LOW, high: `PMA_R0_HIGH, attr: `PMA_R0_ATTR},
    '{low: `PMA_R1_LOW, high: `PMA_R1_HIGH, attr: `PMA_R1_ATTR},
    '{low: `PMA_R2_LOW, high: `PMA_R2_HIGH, attr: `PMA_R2_ATTR}
  };

  word_addr_t  word_addr;
  logic        hit;
  region_idx_t match_idx;
  logic        misaligned;

  assign word_addr = head_i.addr[31:2];

  //////////////////////////////
  // Region match
  //////////////////////////////

  // Scan from the top so that the lowest matching index is the one left standing
  always_comb begin
    hit       = 1'b0;
    match_idx = '0;
    for (int i = `PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= REGION_TAB[i].low) && (word_addr < REGION_TAB[i].high)) begin
        hit       = 1'b1;
        match_idx = region_idx_t'(i);
      end
    end
  end

  // Unmapped addresses get all attributes cleared
  assign attr_o = hit ? REGION_TAB[match_idx].attr : PMA_ATTR_NONE;

  //////////////////////////////
  // Fault rules
  //////////////////////////////

  // Alignment from access size and the low byte address bits
  always_comb begin
    case (head_i.size)
      SIZE_HALF: misaligned = head_i.addr[0];
      SIZE_WORD: misaligned = (head_i.addr[1:0] != 2'b00);
      default:   misaligned = 1'b0;
    endcase
  end

  // Fetch and misaligned need main memory, atomics need atomic support
  assign fault_o = (head_i.instr  && !attr_o.main)   ||
                   (misaligned    && !attr_o.main)   ||
                   (head_i.atomic && !attr_o.atomic);

  // Bit 1 cacheable, bit 0 bufferable
  assign memtype_o = {attr_o.cacheable, attr_o.bufferable};

endmodule

/* hw/pma_pkg.sv */
// Types for physical memory attribute regions and the bus memory type
// Imported by the lookup and by every block that carries a memory type
package pma_pkg;

  //////////////////////////////
  // Addresses and indices
  //////////////////////////////

  // Word address, byte address bits [31:2]
  typedef logic [29:0] word_addr_t;

  // Index into the region table
  typedef logic [1:0] region_idx_t;

  // Bus memory type
  // bit 0 bufferable, bit 1 cacheable
  typedef logic [1:0] memtype_t;

  //////////////////////////////
  // Attributes
  //////////////////////////////

  typedef struct packed {
    logic main;
    logic atomic;
    logic bufferable;
    logic cacheable;
  } pma_attr_t;

  // One table entry, low bound inclusive, high bound exclusive
  typedef struct packed {
    word_addr_t low;
    word_addr_t high;
    pma_attr_t  attr;
  } pma_region_t;

  // Attributes of an address outside every region
  localparam pma_attr_t PMA_ATTR_NONE = '0;

endpackage

/* list.f */
+incdir+hw
hw/pma_pkg.sv
hw/mpu_pkg.sv
hw/mpu_req_fifo.sv
hw/pma_lookup.sv
hw/mpu_ctrl.sv
hw/mpu_resp_mux.sv
hw/mpu_top.sv
testbench/tb_mpu.sv

/* testbench/tb_mpu.sv */
// Directed testbench of the MPU top level with a credit-based bus model
// Core side issues requests on the falling edge and monitors sample on the rising edge
`timescale 1ns/100ps

`include "mpu_settings.svh"

module tb_mpu import mpu_pkg::*, pma_pkg::*; ();

  localparam int WAIT_LIMIT = 200;
  // Cycles between a bus request and its response
  localparam int BUS_LAT    = 3;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       core_req_valid;
  core_req_t  core_req;
  logic       core_credit;
  logic       core_resp_valid;
  core_resp_t core_resp;
  logic       bus_req_valid;
  bus_req_t   bus_req;
  logic       bus_credit = 1'b0;
  logic       bus_resp_valid = 1'b0;
  data_t      bus_rdata = '0;

  // Expected traffic that the issuing side writes and the monitor walks
  core_resp_t exp_resp [$];
  bus_req_t   exp_bus [$];
  int         resp_idx = 0;
  int         bus_idx = 0;
  // Requests seen on the bus that the bus model walks
  addr_t      pend_addr [$];
  int         pend_cycle [$];
  int         pend_idx = 0;
  int         cycle = 0;
  int         issued_cnt = 0;
  int         credit_ret_cnt = 0;
  logic       hold_bus = 1'b0;
  // Bus response seen at the previous rising edge
  logic       bus_resp_prev = 1'b0;
  logic [31:0] rng_state = 32'h391027c8;

  always #10 clk = ~clk;

  mpu_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid),
    .core_req_i        (core_req),
    .core_credit_o     (core_credit),
    .core_resp_valid_o (core_resp_valid),
    .core_resp_o       (core_resp),
    .bus_req_valid_o   (bus_req_valid),
    .bus_req_o         (bus_req),
    .bus_credit_i      (bus_credit),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_rdata_i       (bus_rdata)
  );

  //////////////////////////////
  // Helpers and reference model
  //////////////////////////////

  task automatic abort_test();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Read data the bus model returns for an address
  function automatic data_t bus_data(input addr_t addr);
    return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_3c3c;
  endfunction

  // Credits the core holds right now
  function automatic int credits_held();
    return `MPU_REQ_DEPTH - issued_cnt + credit_ret_cnt;
  endfunction

  function automatic logic in_range(input word_addr_t wa, input word_addr_t lo,
                                    input word_addr_t hi);
    return (wa >= lo) && (wa < hi);
  endfunction

  // First region in table order wins
  function automatic pma_attr_t region_attr(input addr_t addr);
    word_addr_t wa;
    wa = addr[31:2];
    if (in_range(wa, `PMA_R0_LOW, `PMA_R0_HIGH)) begin
      return `PMA_R0_ATTR;
    end else if (in_range(wa, `PMA_R1_LOW, `PMA_R1_HIGH)) begin
      return `PMA_R1_ATTR;
    end else if (in_range(wa, `PMA_R2_LOW, `PMA_R2_HIGH)) begin
      return `PMA_R2_ATTR;
    end
    return '0;
  endfunction

  function automatic memtype_t memtype_of(input addr_t addr);
    pma_attr_t attr;
    attr = region_attr(addr);
    return {attr.cacheable, attr.bufferable};
  endfunction

  function automatic logic exp_fault_of(input addr_t addr, input access_size_e size,
                                        input logic instr, input logic atomic);
    pma_attr_t attr;
    logic      mis;
    attr = region_attr(addr);
    mis  = ((size == SIZE_HALF) && addr[0]) || ((size == SIZE_WORD) && (addr[1:0] != 2'b00));
    return ((instr || mis) && !attr.main) || (atomic && !attr.atomic);
  endfunction

  //////////////////////////////
  // Bus model and monitor
  //////////////////////////////

  // One response and one credit per request BUS_LAT cycles later unless held
  always @(negedge clk) begin
    if (!hold_bus && (pend_idx < pend_addr.size()) &&
        (cycle >= pend_cycle[pend_idx] + BUS_LAT)) begin
      bus_resp_valid = 1'b1;
      bus_credit     = 1'b1;
      bus_rdata      = bus_data(pend_addr[pend_idx]);
      pend_idx       = pend_idx + 1;
    end else begin
      bus_resp_valid = 1'b0;
      bus_credit     = 1'b0;
    end
  end

  // Outputs are read before the edge updates them
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst_n) begin
      if (core_credit) begin
        credit_ret_cnt = credit_ret_cnt + 1;
      end
      assert (credits_held() <= `MPU_REQ_DEPTH) else begin
        $display("More core credits returned than requests were issued");
        abort_test();
      end
      if (bus_req_valid) begin
        pend_addr.push_back(bus_req.addr);
        pend_cycle.push_back(cycle);
        assert (bus_idx < exp_bus.size()) else begin
          $display("Unexpected bus request to address %h", bus_req.addr);
          abort_test();
        end
        assert (bus_req == exp_bus[bus_idx]) else begin
          $display("Error at %0t: bus_req_o is %h, expected %h",
                   $time, bus_req, exp_bus[bus_idx]);
          abort_test();
        end
        // Pop of a legal request returns the core credit with the bus request
        assert (core_credit) else begin
          $display("Error at %0t: core_credit_o is %b with a bus request, expected 1",
                   $time, core_credit);
          abort_test();
        end
        bus_idx = bus_idx + 1;
      end
      // Bus data reaches the core exactly one cycle after the bus returns it
      assert ((core_resp_valid && (core_resp.status == MPU_OK)) == bus_resp_prev) else begin
        $display("Error at %0t: core_resp_valid_o with OK status is %b, expected %b",
                 $time, core_resp_valid && (core_resp.status == MPU_OK), bus_resp_prev);
        abort_test();
      end
      if (core_resp_valid) begin
        assert (resp_idx < exp_resp.size()) else begin
          $display("Response to the core without a pending request");
          abort_test();
        end
        assert (core_resp == exp_resp[resp_idx]) else begin
          $display("Error at %0t: core_resp_o is %h, expected %h",
                   $time, core_resp, exp_resp[resp_idx]);
          abort_test();
        end
        resp_idx = resp_idx + 1;
      end
      bus_resp_prev = bus_resp_valid;
    end
  end

  //////////////////////////////
  // Core driver
  //////////////////////////////

  task automatic wait_credit();
    int waited;
    waited = 0;
    while ((credits_held() == 0) && (waited < WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    assert (credits_held() > 0) else begin
      $display("Timeout waiting for a core credit");
      abort_test();
    end
  endtask

  // Issue one request for a cycle and record what must come back
  task automatic issue_req(input addr_t addr, input logic we, input data_t wdata,
                           input access_size_e size, input logic instr,
                           input logic atomic, input logic exp_fault,
                           input memtype_t exp_mt);
    core_req_t  req;
    bus_req_t   breq;
    core_resp_t resp;
    req.addr   = addr;
    req.we     = we;
    req.wdata  = wdata;
    req.size   = size;
    req.instr  = instr;
    req.atomic = atomic;
    wait_credit();
    if (exp_fault) begin
      resp.rdata  = '0;
      resp.status = we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end else begin
      breq.addr    = addr;
      breq.we      = we;
      breq.wdata   = wdata;
      breq.size    = size;
      breq.memtype = exp_mt;
      exp_bus.push_back(breq);
      resp.rdata  = bus_data(addr);
      resp.status = MPU_OK;
    end
    exp_resp.push_back(resp);
    core_req       = req;
    core_req_valid = 1'b1;
    issued_cnt     = issued_cnt + 1;
    @(negedge clk);
    core_req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (((resp_idx < exp_resp.size()) || (bus_idx < exp_bus.size())) &&
           (waited < WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    assert ((resp_idx == exp_resp.size()) && (bus_idx == exp_bus.size())) else begin
      $display("Timeout waiting for %0d core responses", exp_resp.size() - resp_idx);
      abort_test();
    end
  endtask

  task automatic check_reset_state();
    assert (!bus_req_valid) else begin
      $display("Error at %0t: bus_req_valid_o is %b under reset, expected 0",
               $time, bus_req_valid);
      abort_test();
    end
    assert (!core_credit) else begin
      $display("Error at %0t: core_credit_o is %b under reset, expected 0",
               $time, core_credit);
      abort_test();
    end
    assert (!core_resp_valid) else begin
      $display("Error at %0t: core_resp_valid_o is %b under reset, expected 0",
               $time, core_resp_valid);
      abort_test();
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic plain_access_test();
    issue_req(32'h0000_1000, 1'b1, 32'hcafe_0001, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd3);
    issue_req(32'h0000_1000, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd3);
    // I/O region with bufferable only
    issue_req(32'h1000_0040, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd1);
    drain_responses();
  endtask

  task automatic blocked_access_test();
    issue_req(32'h1000_0100, 1'b0, 32'h0, SIZE_WORD, 1'b1, 1'b0, 1'b1, 2'd0);
    issue_req(32'h1000_0102, 1'b1, 32'h1234_5678, SIZE_WORD, 1'b0, 1'b0, 1'b1, 2'd0);
    issue_req(32'h1000_0001, 1'b0, 32'h0, SIZE_HALF, 1'b0, 1'b0, 1'b1, 2'd0);
    // Main memory tolerates misalignment
    issue_req(32'h0000_2001, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd3);
    drain_responses();
  endtask

  task automatic region_priority_test();
    // Region 0 grants the atomic in its overlap with region 2
    issue_req(32'h0900_0000, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b1, 1'b0, 2'd3);
    // Region 2 above region 0
    issue_req(32'h1400_0000, 1'b1, 32'h0bad_0001, SIZE_WORD, 1'b0, 1'b1, 1'b1, 2'd0);
    // Unmapped space
    issue_req(32'h3000_0000, 1'b0, 32'h0, SIZE_WORD, 1'b1, 1'b0, 1'b1, 2'd0);
    issue_req(32'h3000_0000, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd0);
    drain_responses();
  endtask

  task automatic backpressure_test();
    int seen_start;
    hold_bus   = 1'b1;
    seen_start = pend_addr.size();
    for (int i = 0; i < `MPU_REQ_DEPTH + `MPU_BUS_CREDITS; i++) begin
      issue_req(32'h0000_3000 + i * 4, 1'b0, 32'h0, SIZE_WORD, 1'b0, 1'b0, 1'b0, 2'd3);
    end
    // Window long enough for any extra request to show up
    repeat (10) @(negedge clk);
    assert (pend_addr.size() - seen_start == `MPU_BUS_CREDITS) else begin
      $display("Error at %0t: bus_req_valid_o pulse count is %0d, expected %0d",
               $time, pend_addr.size() - seen_start, `MPU_BUS_CREDITS);
      abort_test();
    end
    assert (credits_held() == 0) else begin
      $display("Error at %0t: core credits are %0d, expected 0", $time, credits_held());
      abort_test();
    end
    hold_bus = 1'b0;
    drain_responses();
  endtask

  task automatic random_mix_test(input int num);
    logic [31:0]  r;
    logic [31:0]  s;
    addr_t        addr;
    access_size_e size;
    logic         we;
    logic         instr;
    logic         atomic;
    for (int i = 0; i < num; i++) begin
      r = xorshift32();
      s = xorshift32();
      case (r[27:26])
        2'd0:    addr = {6'b000000, r[25:0]};
        2'd1:    addr = {6'b000010, r[25:0]};
        2'd2:    addr = {6'b000101, r[25:0]};
        default: addr = {6'b001100, r[25:0]};
      endcase
      size   = (s[1:0] == 2'b11) ? SIZE_WORD : access_size_e'(s[1:0]);
      instr  = (s[4:2] == 3'b000);
      atomic = (s[7:5] == 3'b000);
      we     = s[8];
      // Every fourth request is a fetch into I/O queued behind earlier reads
      if (i % 4 == 3) begin
        addr  = {6'b000101, r[25:0]};
        instr = 1'b1;
        we    = 1'b0;
      end
      issue_req(addr, we, xorshift32(), size, instr, atomic,
                exp_fault_of(addr, size, instr, atomic), memtype_of(addr));
    end
    drain_responses();
    assert (credit_ret_cnt == issued_cnt) else begin
      $display("Error at %0t: core_credit_o count is %0d, expected %0d",
               $time, credit_ret_cnt, issued_cnt);
      abort_test();
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    repeat (4) @(negedge clk);
    check_reset_state();
    rst_n = 1'b1;
    @(negedge clk);
    plain_access_test();
    blocked_access_test();
    region_priority_test();
    backpressure_test();
    random_mix_test(24);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
